/* src/ch3_consts.svh */
`ifndef CH3_CONSTS_SVH
`define CH3_CONSTS_SVH

// channel 3 register addresses
`define CH3_ADDR_NR30 16'hff1a  // dac enable
`define CH3_ADDR_NR31 16'hff1b  // length load
`define CH3_ADDR_NR32 16'hff1c  // volume code
`define CH3_ADDR_NR33 16'hff1d  // freq low byte
`define CH3_ADDR_NR34 16'hff1e  // trigger, length enable, freq high bits

// wave ram window
`define CH3_WAVE_BASE 16'hff30
`define CH3_WAVE_LAST 16'hff3f

// counter widths
`define CH3_FREQ_W 11
`define CH3_LEN_W  8
`define CH3_POS_W  5

`endif

/* src/ch3_wave_pkg.sv */
`default_nettype none

`include "ch3_consts.svh"

package ch3_wave_pkg;

	typedef logic [3:0] sample_t;                  // one wave nibble

	typedef logic [`CH3_POS_W-1:0] wave_pos_t;     // 32 nibbles per pass

	// nr32 bits 6:5
	typedef enum logic [1:0] {
		VOL_MUTE    = 2'b00,
		VOL_FULL    = 2'b01,
		VOL_HALF    = 2'b10,
		VOL_QUARTER = 2'b11
	} vol_code_t;

endpackage

`default_nettype wire

/* src/ch3_regs_pkg.sv */
`default_nettype none

`include "ch3_consts.svh"

package ch3_regs_pkg;

	// one cpu bus cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        wr;
		logic        rd;
	} bus_req_t;

	// register image seen by the channel blocks
	typedef struct packed {
		logic                    dac_on;    // nr30 bit 7
		ch3_wave_pkg::vol_code_t vol_code;  // nr32 bits 6:5
		logic [`CH3_FREQ_W-1:0]  freq;      // nr33 + nr34 bits 2:0
		logic                    len_en;    // nr34 bit 6
	} ch3_regs_t;

	typedef struct packed {
		logic [`CH3_LEN_W-1:0] value;
		logic                  load;        // one cycle
	} len_load_t;

endpackage

`default_nettype wire

/* src/ch3_reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ch3_consts.svh"

module ch3_reg_file (
	input  wire logic                    cery_2mhz,
	input  wire logic                    reset,
	input  ch3_regs_pkg::bus_req_t       bus,
	output ch3_regs_pkg::ch3_regs_t      regs,
	output logic                         trigger,
	output ch3_regs_pkg::len_load_t      len_load
);

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			regs     <= '0;
			trigger  <= 1'b0;
			len_load <= '0;
		end else begin
			trigger       <= 1'b0;  // strobes last one cycle
			len_load.load <= 1'b0;
			if (bus.wr) begin
				case (bus.addr)
					`CH3_ADDR_NR30: begin
						regs.dac_on <= bus.wdata[7];
					end
					`CH3_ADDR_NR31: begin
						len_load.value <= bus.wdata;
						len_load.load  <= 1'b1;
					end
					`CH3_ADDR_NR32: begin
						regs.vol_code <= ch3_wave_pkg::vol_code_t'(bus.wdata[6:5]);
					end
					`CH3_ADDR_NR33: begin
						regs.freq[7:0] <= bus.wdata;
					end
					`CH3_ADDR_NR34: begin
						regs.freq[`CH3_FREQ_W-1:8] <= bus.wdata[2:0];
						regs.len_en                <= bus.wdata[6];
						trigger                    <= bus.wdata[7];  // sees the new freq
					end
					default: begin
					end
				endcase
			end
		end
	end

endmodule

`default_nettype wire

/* src/ch3_freq_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ch3_consts.svh"

module ch3_freq_timer (
	input  wire logic                   cery_2mhz,
	input  wire logic                   reset,
	input  wire logic [`CH3_FREQ_W-1:0] freq,
	input  wire logic                   trigger,
	input  wire logic                   active,
	output ch3_wave_pkg::wave_pos_t     pos
);

	logic [`CH3_FREQ_W-1:0] period_cnt;
	logic                   period_done;

	// 2048 - freq cycles per step
	assign period_done = &period_cnt;

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			period_cnt <= '0;
			pos        <= '0;
		end else if (trigger) begin
			period_cnt <= freq;
			pos        <= '0;
		end else if (active) begin
			if (period_done) begin
				period_cnt <= freq;       // reload on overflow
				pos        <= pos + 1'b1;  // wraps after 31
			end else begin
				period_cnt <= period_cnt + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* src/ch3_length_timer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ch3_consts.svh"

module ch3_length_timer (
	input  wire logic               cery_2mhz,
	input  wire logic               reset,
	input  wire logic               tick_256hz,
	input  ch3_regs_pkg::len_load_t len_load,
	input  wire logic               len_en,
	input  wire logic               dac_on,
	input  wire logic               trigger,
	output logic                    active
);

	logic [`CH3_LEN_W-1:0] len_cnt;
	logic                  len_step;
	logic                  expired;

	assign len_step = tick_256hz && len_en && active;

	always_ff @(posedge cery_2mhz) begin
		if (reset) begin
			len_cnt <= '0;
			expired <= 1'b0;
			active  <= 1'b0;
		end else begin
			if (len_load.load)
				len_cnt <= len_load.value;
			else if (len_step)
				len_cnt <= len_cnt + 1'b1;

			if (len_load.load || trigger)
				expired <= 1'b0;
			else if (len_step && (&len_cnt))
				expired <= 1'b1;  // overflow out of 255

			// dac off wins over everything in the active latch
			if (!dac_on)
				active <= 1'b0;
			else if (trigger)
				active <= 1'b1;
			else if (expired)
				active <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* src/ch3_wave_ram.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ch3_consts.svh"

module ch3_wave_ram (
	input  wire logic                cery_2mhz,
	input  wire logic                reset,
	input  ch3_regs_pkg::bus_req_t   bus,
	input  wire logic                active,
	input  ch3_wave_pkg::wave_pos_t  pos,
	output logic [7:0]               rdata,
	output ch3_wave_pkg::sample_t    sample
);

	logic [7:0] mem [16];
	logic       in_range;
	logic [7:0] play_byte;

	assign in_range  = (bus.addr >= `CH3_WAVE_BASE) && (bus.addr <= `CH3_WAVE_LAST);
	assign play_byte = mem[pos[`CH3_POS_W-1:1]];  // two nibbles per byte

	always_ff @(posedge cery_2mhz) begin
		if (bus.wr && in_range)
			mem[bus.addr[3:0]] <= bus.wdata;
		sample <= pos[0] ? play_byte[3:0] : play_byte[7:4];  // high nibble first
	end

	// cpu readback returns the playing byte while active
	always_ff @(posedge cery_2mhz) begin
		if (reset)
			rdata <= '0;
		else if (bus.rd && in_range)
			rdata <= active ? play_byte : mem[bus.addr[3:0]];
		else
			rdata <= '0;
	end

endmodule

`default_nettype wire

/* src/ch3_volume_shift.sv */
`timescale 1ns/10ps
`default_nettype none

module ch3_volume_shift (
	input  ch3_wave_pkg::sample_t   sample,
	input  ch3_wave_pkg::vol_code_t vol_code,
	input  wire logic               active,
	output ch3_wave_pkg::sample_t   wave_dac
);

	ch3_wave_pkg::sample_t shifted;

	always_comb begin
		case (vol_code)
			ch3_wave_pkg::VOL_MUTE:    shifted = '0;
			ch3_wave_pkg::VOL_FULL:    shifted = sample;
			ch3_wave_pkg::VOL_HALF:    shifted = sample >> 1;
			ch3_wave_pkg::VOL_QUARTER: shifted = sample >> 2;
			default:                   shifted = '0;
		endcase
	end

	assign wave_dac = active ? shifted : '0;  // silent when off

endmodule

`default_nettype wire

/* src/channel3.sv */
`timescale 1ns/10ps
`default_nettype none

module channel3 (
	input  wire logic              cery_2mhz,
	input  wire logic              reset,
	input  ch3_regs_pkg::bus_req_t bus,
	input  wire logic              tick_256hz,
	output logic [7:0]             rdata,
	output logic                   ch3_active,
	output ch3_wave_pkg::sample_t  wave_dac
);

	ch3_regs_pkg::ch3_regs_t regs;
	ch3_regs_pkg::len_load_t len_load;
	logic                    trigger;
	ch3_wave_pkg::wave_pos_t pos;
	ch3_wave_pkg::sample_t   sample;

	ch3_reg_file u_reg_file (
		.cery_2mhz (cery_2mhz),
		.reset     (reset),
		.bus       (bus),
		.regs      (regs),
		.trigger   (trigger),
		.len_load  (len_load)
	);

	ch3_freq_timer u_freq_timer (
		.cery_2mhz (cery_2mhz),
		.reset     (reset),
		.freq      (regs.freq),
		.trigger   (trigger),
		.active    (ch3_active),
		.pos       (pos)
	);

	ch3_length_timer u_length_timer (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.tick_256hz (tick_256hz),
		.len_load   (len_load),
		.len_en     (regs.len_en),
		.dac_on     (regs.dac_on),
		.trigger    (trigger),
		.active     (ch3_active)
	);

	ch3_wave_ram u_wave_ram (
		.cery_2mhz (cery_2mhz),
		.reset     (reset),
		.bus       (bus),
		.active    (ch3_active),
		.pos       (pos),
		.rdata     (rdata),
		.sample    (sample)
	);

	ch3_volume_shift u_volume_shift (
		.sample   (sample),
		.vol_code (regs.vol_code),
		.active   (ch3_active),
		.wave_dac (wave_dac)
	);

endmodule

`default_nettype wire

/* verification/channel3_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "ch3_consts.svh"

module channel3_tb;

	typedef enum logic [2:0] {
		OP_WRITE,   // addr, data
		OP_READ,    // addr, expected byte
		OP_WAIT,    // cycle count in addr
		OP_TICK,
		OP_DAC,     // nibble position in addr, volume code in data
		OP_ACTIVE   // expected level in expv
	} op_t;

	typedef struct packed {
		op_t         op;
		logic [2:0]  test_id;
		logic [15:0] addr;
		logic [7:0]  data;
		logic [7:0]  expv;
	} step_t;

	localparam logic [15:0] NO_POS      = 16'hffff;  // silent channel, expect expv
	localparam logic [10:0] FREQ        = 11'd2044;
	localparam int          STEP_CYCLES = 2048 - FREQ;
	localparam int          MARGIN      = 64;

	logic                   cery_2mhz;
	logic                   reset;
	ch3_regs_pkg::bus_req_t bus;
	logic                   tick_256hz;
	logic [7:0]             rdata;
	logic                   ch3_active;
	ch3_wave_pkg::sample_t  wave_dac;

	step_t      steps[$];
	logic [7:0] wave_ref [16];  // what the wave ram should hold
	integer     seed = 32'h1b7b_427c;
	int         cycle_count = 0;
	int         cycle_limit = 0;
	int         checks = 0;
	int         errors = 0;
	int         test_checks = 0;
	int         test_errors = 0;

	channel3 dut_i (
		.cery_2mhz  (cery_2mhz),
		.reset      (reset),
		.bus        (bus),
		.tick_256hz (tick_256hz),
		.rdata      (rdata),
		.ch3_active (ch3_active),
		.wave_dac   (wave_dac)
	);

	initial begin
		cery_2mhz = 1'b0;
		forever #10 cery_2mhz = ~cery_2mhz;
	end

	always @(posedge cery_2mhz) begin
		cycle_count = cycle_count + 1;
		if (cycle_limit > 0 && cycle_count > cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic tally(input bit failed);
		checks++;
		test_checks++;
		if (failed) begin
			errors++;
			test_errors++;
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		tally(got !== exp);
	endtask

	task automatic check_sample(input string name, input ch3_wave_pkg::sample_t got,
			input ch3_wave_pkg::sample_t exp);
		if (got !== exp)
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		tally(got !== exp);
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
			$display("** Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		tally(got !== exp);
	endtask

	// high nibble on even positions, then the volume shift
	function automatic ch3_wave_pkg::sample_t expected_dac(input logic [4:0] pos,
			input logic [1:0] vol);
		logic [7:0] b;
		logic [3:0] nib;
		b   = wave_ref[pos[4:1]];
		nib = pos[0] ? b[3:0] : b[7:4];
		case (vol)
			2'd0:    return 4'h0;
			2'd1:    return nib;
			2'd2:    return nib >> 1;
			default: return nib >> 2;
		endcase
	endfunction

	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		bus.addr  = addr;
		bus.wdata = data;
		bus.wr    = 1'b1;
		@(negedge cery_2mhz);
		bus = '0;
	endtask

	task automatic bus_read(input logic [15:0] addr, output logic [7:0] data);
		bus.addr = addr;
		bus.rd   = 1'b1;
		@(negedge cery_2mhz);
		bus  = '0;
		data = rdata;  // registered one cycle after rd
	endtask

	task automatic pulse_tick();
		tick_256hz = 1'b1;
		@(negedge cery_2mhz);
		tick_256hz = 1'b0;
	endtask

	task automatic add_step(input op_t op, input logic [2:0] id, input logic [15:0] addr,
			input logic [7:0] data, input logic [7:0] expv);
		step_t s;
		s.op      = op;
		s.test_id = id;
		s.addr    = addr;
		s.data    = data;
		s.expv    = expv;
		steps.push_back(s);
	endtask

	task automatic build_table();
		logic [31:0] rnd;
		int          i;
		add_step(OP_ACTIVE, 1, 0, 0, 0);
		add_step(OP_DAC, 1, NO_POS, 0, 0);
		for (i = 0; i < 16; i++) begin
			rnd         = $random(seed);
			wave_ref[i] = rnd[7:0];
			add_step(OP_WRITE, 1, 16'(`CH3_WAVE_BASE + i), wave_ref[i], 0);
		end
		for (i = 0; i < 16; i++)
			add_step(OP_READ, 1, 16'(`CH3_WAVE_BASE + i), 0, wave_ref[i]);
		add_step(OP_READ, 1, `CH3_ADDR_NR32, 0, 0);  // not a wave address

		add_step(OP_WRITE, 2, `CH3_ADDR_NR34, 8'h80, 0);  // trigger with the dac still off
		add_step(OP_WAIT, 2, 2, 0, 0);
		add_step(OP_ACTIVE, 2, 0, 0, 0);
		add_step(OP_WRITE, 2, `CH3_ADDR_NR30, 8'h80, 0);
		add_step(OP_WRITE, 2, `CH3_ADDR_NR32, 8'h20, 0);  // full volume
		add_step(OP_WRITE, 2, `CH3_ADDR_NR33, FREQ[7:0], 0);
		add_step(OP_WRITE, 2, `CH3_ADDR_NR34, {5'b10000, FREQ[10:8]}, 0);
		add_step(OP_ACTIVE, 2, 0, 0, 0);
		add_step(OP_WAIT, 2, 1, 0, 0);
		add_step(OP_ACTIVE, 2, 0, 0, 1);

		// one full pass plus the wrap back to position 0
		add_step(OP_WAIT, 3, 1, 0, 0);
		add_step(OP_DAC, 3, 0, 1, 0);
		for (i = 1; i <= 32; i++) begin
			add_step(OP_WAIT, 3, 16'(STEP_CYCLES - 1), 0, 0);
			add_step(OP_DAC, 3, 16'((i - 1) % 32), 1, 0);  // pos just stepped, sample lags
			add_step(OP_WAIT, 3, 1, 0, 0);
			add_step(OP_DAC, 3, 16'(i % 32), 1, 0);
		end

		add_step(OP_WRITE, 4, `CH3_ADDR_NR32, 8'h40, 0);  // half
		add_step(OP_DAC, 4, 0, 2, 0);
		add_step(OP_WRITE, 4, `CH3_ADDR_NR32, 8'h60, 0);  // quarter
		add_step(OP_DAC, 4, 0, 3, 0);
		add_step(OP_WRITE, 4, `CH3_ADDR_NR32, 8'h00, 0);  // mute
		add_step(OP_DAC, 4, 0, 0, 0);
		add_step(OP_WRITE, 4, `CH3_ADDR_NR32, 8'h20, 0);
		add_step(OP_DAC, 4, 1, 1, 0);

		add_step(OP_WRITE, 5, `CH3_ADDR_NR31, 8'd253, 0);
		add_step(OP_WRITE, 5, `CH3_ADDR_NR34, {5'b01000, FREQ[10:8]}, 0);  // length on
		for (i = 0; i < 3; i++)
			add_step(OP_TICK, 5, 0, 0, 0);
		add_step(OP_ACTIVE, 5, 0, 0, 1);
		add_step(OP_WAIT, 5, 1, 0, 0);
		add_step(OP_ACTIVE, 5, 0, 0, 0);
		add_step(OP_DAC, 5, NO_POS, 0, 0);

		add_step(OP_WRITE, 6, `CH3_ADDR_NR34, {5'b10000, FREQ[10:8]}, 0);
		add_step(OP_WAIT, 6, 1, 0, 0);
		add_step(OP_ACTIVE, 6, 0, 0, 1);
		add_step(OP_WAIT, 6, 10, 0, 0);
		add_step(OP_DAC, 6, 2, 1, 0);  // third nibble after two steps
		add_step(OP_READ, 6, 16'(`CH3_WAVE_BASE + 9), 0, wave_ref[1]);  // playing byte wins
		add_step(OP_WRITE, 6, `CH3_ADDR_NR30, 8'h00, 0);
		add_step(OP_ACTIVE, 6, 0, 0, 1);
		add_step(OP_WAIT, 6, 1, 0, 0);
		add_step(OP_ACTIVE, 6, 0, 0, 0);
		add_step(OP_DAC, 6, NO_POS, 0, 0);
	endtask

	function automatic int table_cycles();
		int total;
		total = 0;
		foreach (steps[i]) begin
			if (steps[i].op == OP_WAIT)
				total += steps[i].addr;
			else if (steps[i].op inside {OP_WRITE, OP_READ, OP_TICK})
				total += 1;
		end
		return total;
	endfunction

	task automatic run_step(input step_t s);
		logic [7:0] got;
		case (s.op)
			OP_WRITE: bus_write(s.addr, s.data);
			OP_READ: begin
				bus_read(s.addr, got);
				check_byte("rdata", got, s.expv);
			end
			OP_WAIT: repeat (s.addr) @(negedge cery_2mhz);
			OP_TICK: pulse_tick();
			OP_DAC: begin
				if (s.addr == NO_POS)
					check_sample("wave_dac", wave_dac, s.expv[3:0]);
				else
					check_sample("wave_dac", wave_dac, expected_dac(s.addr[4:0], s.data[1:0]));
			end
			OP_ACTIVE: check_bit("ch3_active", ch3_active, s.expv[0]);
			default: begin
				$display("step table holds an unknown operation");
				tally(1'b1);
			end
		endcase
	endtask

	task automatic report_test(input logic [2:0] id);
		$display("test %0d finished: %0d checks, %0d errors", id, test_checks, test_errors);
		test_checks = 0;
		test_errors = 0;
	endtask

	initial begin
		logic [2:0] cur_id;
		reset      = 1'b1;
		bus        = '0;
		tick_256hz = 1'b0;
		build_table();
		cycle_limit = 5 + MARGIN + table_cycles();
		repeat (4) @(posedge cery_2mhz);
		@(negedge cery_2mhz);
		reset  = 1'b0;
		cur_id = steps[0].test_id;
		foreach (steps[i]) begin
			if (steps[i].test_id != cur_id) begin
				report_test(cur_id);
				cur_id = steps[i].test_id;
			end
			run_step(steps[i]);
		end
		report_test(cur_id);
		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/ch3_wave_pkg.sv
src/ch3_regs_pkg.sv
src/ch3_reg_file.sv
src/ch3_freq_timer.sv
src/ch3_length_timer.sv
src/ch3_wave_ram.sv
src/ch3_volume_shift.sv
src/channel3.sv
verification/channel3_tb.sv
